// File: logic/uc_bridge_config.svh
// uncached bridge widths shared by the sequencer, the engine and the top level
`ifndef UC_BRIDGE_CONFIG_SVH
`define UC_BRIDGE_CONFIG_SVH

// physical address
`define UC_ADDR_W 32

// cpu side word, one lane of the beat
`define UC_WORD_W 32

// tilelink data beat, one 16-byte line
`define UC_BEAT_W 128

// word lanes per beat
`define UC_LANES 4

// one strobe bit per beat byte
`define UC_MASK_W 16

`endif

// File: logic/uc_bridge_pkg.sv
// types for the uncached tilelink-ul bridge: sizes, opcodes and fsm states
`default_nettype none

package uc_bridge_pkg;

    // log2 of the access size in bytes, same coding as tilelink a_size
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } access_size_e;

    // A channel, only the two uncached requests
    typedef enum logic [2:0] {
        PutFullData = 3'd0,
        Get         = 3'd4
    } tl_a_op_e;

    // D channel responses to the requests above
    typedef enum logic [2:0] {
        AccessAck     = 3'd0,
        AccessAckData = 3'd1
    } tl_d_op_e;

    // request sequencer
    typedef enum logic [1:0] {
        S_FREE = 2'd0, // waiting for a cpu request
        S_ULD  = 2'd1, // load, calling the engine
        S_UST  = 2'd2, // store, calling the engine
        S_RET  = 2'd3  // load result back to the cpu
    } seq_state_e;

    // uncached engine
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_TLA  = 2'd1, // Get or PutFullData on A
        S_WTLD = 2'd2, // waiting for AccessAck
        S_RTLD = 2'd3  // waiting for AccessAckData
    } eng_state_e;

endpackage

`default_nettype wire

// File: logic/unc_call_if.sv
// call channel from the request sequencer into the uncached engine
`default_nettype none
`include "uc_bridge_config.svh"

interface unc_call_if;
    import uc_bridge_pkg::*;

    logic                  cal;   // held until ret
    logic                  wreq;  // store when high
    access_size_e          size;
    logic [`UC_ADDR_W-1:0] addr;
    logic [`UC_WORD_W-1:0] wdata;

    // single cycle, rdata valid with it
    logic                  ret;
    logic [`UC_BEAT_W-1:0] rdata; // whole D beat

    modport caller (
        output cal, wreq, size, addr, wdata,
        input  ret, rdata
    );

    modport callee (
        input  cal, wreq, size, addr, wdata,
        output ret, rdata
    );

endinterface

`default_nettype wire

// File: logic/uncached_req_seq.sv
// uncached request sequencer, takes one cpu load or store and calls the engine
`default_nettype none
`include "uc_bridge_config.svh"

module uncached_req_seq (
    input  logic                          clk,
    input  logic                          rst_n,

    // cpu request, held until resp_done_o
    input  logic                          req_valid_i,
    input  logic                          req_wr_i,
    input  uc_bridge_pkg::access_size_e   req_size_i,
    input  logic [`UC_ADDR_W-1:0]         req_addr_i,
    input  logic [`UC_WORD_W-1:0]         req_wdata_i,
    output logic                          resp_done_o,
    output logic [2*`UC_WORD_W-1:0]       resp_rdata_o,

    unc_call_if.caller                    call
);
    import uc_bridge_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;

    access_size_e            size_q;
    logic [`UC_ADDR_W-1:0]   addr_q;
    logic [2*`UC_WORD_W-1:0] data_q; // store data in low half, later the load result

    logic [`UC_LANES-1:0][`UC_WORD_W-1:0] beat;
    logic [1:0] lane_lo; // addressed word
    logic [1:0] lane_hi; // odd word of the same doubleword
    logic       take_req;
    logic       load_ret;

    assign beat    = call.rdata;
    assign lane_lo = addr_q[3:2];
    assign lane_hi = {addr_q[3], 1'b1};

    assign take_req = (state_q == S_FREE) && req_valid_i;
    assign load_ret = (state_q == S_ULD) && call.ret;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    // payload, written on acceptance and on load return
    always_ff @(posedge clk) begin
        if (take_req) begin
            size_q <= req_size_i;
            addr_q <= req_addr_i;
            data_q <= {{`UC_WORD_W{1'b0}}, req_wdata_i};
        end else if (load_ret) begin
            // odd word above, addressed word below
            data_q <= {beat[lane_hi], beat[lane_lo]};
        end
    end

    always_comb begin
        state_d     = state_q;
        resp_done_o = 1'b0;
        case (state_q)
            S_FREE: begin
                if (req_valid_i) begin
                    state_d = req_wr_i ? S_UST : S_ULD;
                end
            end
            S_ULD: begin
                if (call.ret) begin
                    state_d = S_RET;
                end
            end
            S_UST: begin
                // store completes with the ack itself
                if (call.ret) begin
                    resp_done_o = 1'b1;
                    state_d     = S_FREE;
                end
            end
            S_RET: begin
                resp_done_o = 1'b1;
                state_d     = S_FREE;
            end
            default: begin
                state_d = S_FREE;
            end
        endcase
    end

    // call payload comes straight from the latched request
    assign call.cal   = (state_q == S_ULD) || (state_q == S_UST);
    assign call.wreq  = (state_q == S_UST);
    assign call.size  = size_q;
    assign call.addr  = addr_q;
    assign call.wdata = data_q[`UC_WORD_W-1:0];

    assign resp_rdata_o = data_q;

endmodule

`default_nettype wire

// File: logic/tl_ul_engine.sv
// uncached engine, one Get or PutFullData beat and its TileLink-UL response
`default_nettype none
`include "uc_bridge_config.svh"

module tl_ul_engine (
    input  logic                          clk,
    input  logic                          rst_n,

    unc_call_if.callee                    call,

    // TileLink A
    output logic                          a_valid_o,
    output uc_bridge_pkg::tl_a_op_e       a_opcode_o,
    output uc_bridge_pkg::access_size_e   a_size_o,
    output logic [`UC_ADDR_W-1:0]         a_address_o,
    output logic [`UC_MASK_W-1:0]         a_mask_o,
    output logic [`UC_BEAT_W-1:0]         a_data_o,
    input  logic                          a_ready_i,

    // TileLink D
    input  logic                          d_valid_i,
    input  uc_bridge_pkg::tl_d_op_e       d_opcode_i,
    input  logic [`UC_BEAT_W-1:0]         d_data_i,
    output logic                          d_ready_o
);
    import uc_bridge_pkg::*;

    eng_state_e state_q;
    eng_state_e state_d;

    logic                                          wreq_q;
    access_size_e                                  size_q;
    logic [`UC_ADDR_W-1:0]                         addr_q;
    logic [`UC_LANES-1:0][`UC_MASK_W/`UC_LANES-1:0] mask_q;
    logic [`UC_LANES-1:0][`UC_MASK_W/`UC_LANES-1:0] mask_d;
    logic [`UC_LANES-1:0][`UC_WORD_W-1:0]          data_q;
    logic [`UC_LANES-1:0][`UC_WORD_W-1:0]          data_d;

    logic [`UC_MASK_W/`UC_LANES-1:0] strb_lo; // addressed lane
    logic [`UC_MASK_W/`UC_LANES-1:0] strb_hi; // odd lane of the doubleword
    logic                            take_cal;
    logic                            d_hit;

    assign take_cal = (state_q == S_IDLE) && call.cal;

    // byte strobes within a lane
    always_comb begin
        case (call.size)
            SZ_BYTE: strb_lo = 4'b0001 << call.addr[1:0];
            SZ_HALF: strb_lo = call.addr[1] ? 4'b1100 : 4'b0011;
            default: strb_lo = 4'b1111;
        endcase
        strb_hi = (call.size == SZ_DWORD) ? 4'b1111 : 4'b0000;
    end

    // place strobes and write data into the beat
    always_comb begin
        mask_d = '0;
        data_d = '0;
        mask_d[{call.addr[3], 1'b1}] = strb_hi;
        mask_d[call.addr[3:2]]       = strb_lo; // wins when both hit the same lane
        data_d[call.addr[3:2]]       = call.wdata;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // A payload, frozen until the next call
    always_ff @(posedge clk) begin
        if (take_cal) begin
            wreq_q <= call.wreq;
            size_q <= call.size;
            addr_q <= call.addr;
            mask_q <= mask_d;
            data_q <= data_d;
        end
    end

    // only the response that matches the request is taken
    assign d_hit = d_valid_i &&
                   (((state_q == S_WTLD) && (d_opcode_i == AccessAck)) ||
                    ((state_q == S_RTLD) && (d_opcode_i == AccessAckData)));

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (call.cal) begin
                    state_d = S_TLA;
                end
            end
            S_TLA: begin
                if (a_ready_i) begin
                    state_d = wreq_q ? S_WTLD : S_RTLD;
                end
            end
            S_WTLD, S_RTLD: begin
                if (d_hit) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    assign a_valid_o   = (state_q == S_TLA);
    assign a_opcode_o  = wreq_q ? PutFullData : Get;
    assign a_size_o    = size_q;
    assign a_address_o = addr_q;
    assign a_mask_o    = mask_q;
    assign a_data_o    = data_q;

    assign d_ready_o  = d_hit;
    assign call.ret   = d_hit;    // same cycle as the D handshake
    assign call.rdata = d_data_i;

endmodule

`default_nettype wire

// File: logic/dcache_uncached_bridge.sv
// data cache uncached bridge, cpu loads and stores over TileLink-UL A and D
`default_nettype none
`include "uc_bridge_config.svh"

module dcache_uncached_bridge (
    input  logic                          clk,
    input  logic                          rst_n,

    // cpu side
    input  logic                          req_valid_i,
    input  logic                          req_wr_i,
    input  uc_bridge_pkg::access_size_e   req_size_i,
    input  logic [`UC_ADDR_W-1:0]         req_addr_i,
    input  logic [`UC_WORD_W-1:0]         req_wdata_i,
    output logic                          resp_done_o,
    output logic [2*`UC_WORD_W-1:0]       resp_rdata_o,

    // TileLink A
    output logic                          a_valid_o,
    output uc_bridge_pkg::tl_a_op_e       a_opcode_o,
    output uc_bridge_pkg::access_size_e   a_size_o,
    output logic [`UC_ADDR_W-1:0]         a_address_o,
    output logic [`UC_MASK_W-1:0]         a_mask_o,
    output logic [`UC_BEAT_W-1:0]         a_data_o,
    input  logic                          a_ready_i,

    // TileLink D
    input  logic                          d_valid_i,
    input  uc_bridge_pkg::tl_d_op_e       d_opcode_i,
    input  logic [`UC_BEAT_W-1:0]         d_data_i,
    output logic                          d_ready_o
);

    unc_call_if call_bus ();

    // latches the cpu request and returns the result
    uncached_req_seq u_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_wr_i     (req_wr_i),
        .req_size_i   (req_size_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .resp_done_o  (resp_done_o),
        .resp_rdata_o (resp_rdata_o),
        .call         (call_bus.caller)
    );

    // one beat out on A, one response back on D
    tl_ul_engine u_eng (
        .clk         (clk),
        .rst_n       (rst_n),
        .call        (call_bus.callee),
        .a_valid_o   (a_valid_o),
        .a_opcode_o  (a_opcode_o),
        .a_size_o    (a_size_o),
        .a_address_o (a_address_o),
        .a_mask_o    (a_mask_o),
        .a_data_o    (a_data_o),
        .a_ready_i   (a_ready_i),
        .d_valid_i   (d_valid_i),
        .d_opcode_i  (d_opcode_i),
        .d_data_i    (d_data_i),
        .d_ready_o   (d_ready_o)
    );

endmodule

`default_nettype wire

// File: tb/dcache_uncached_bridge_sva.sv
// concurrent checks on the bridge handshakes, bound into the top level
`default_nettype none
`include "uc_bridge_config.svh"

module dcache_uncached_bridge_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    a_valid_o,
    input logic                    a_ready_i,
    input logic [2:0]              a_opcode_o,
    input logic [1:0]              a_size_o,
    input logic [`UC_ADDR_W-1:0]   a_address_o,
    input logic [`UC_MASK_W-1:0]   a_mask_o,
    input logic [`UC_BEAT_W-1:0]   a_data_o,
    input logic                    d_valid_i,
    input logic [2:0]              d_opcode_i,
    input logic                    d_ready_o,
    input logic                    resp_done_o
);
    import uc_bridge_pkg::*;

    int unsigned fail_count = 0; // read by the testbench

    // stalled beat holds still
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid_o && !a_ready_i |=> a_valid_o && $stable(a_opcode_o) && $stable(a_size_o)
            && $stable(a_address_o) && $stable(a_mask_o) && $stable(a_data_o))
        else begin $error("A beat changed while a_ready_i was low"); fail_count++; end

    // D taken only with the response that answers the last A opcode
    d_accept: assert property (@(posedge clk) disable iff (!rst_n)
        d_ready_o |-> d_valid_i
            && (d_opcode_i == ((a_opcode_o == Get) ? AccessAckData : AccessAck)))
        else begin $error("d_ready_o high without a matching D response"); fail_count++; end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_done_o |=> !resp_done_o)
        else begin $error("resp_done_o high for two cycles"); fail_count++; end

    // first edge still sees the unreset state, so look one cycle on
    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !a_valid_o && !d_ready_o && !resp_done_o)
        else begin $error("handshake output high during reset"); fail_count++; end

endmodule

`default_nettype wire

// File: tb/tb_dcache_uncached_bridge.sv
// testbench for the uncached bridge, with a TileLink-UL responder and a reference model
`default_nettype none
`include "uc_bridge_config.svh"

module tb_dcache_uncached_bridge;
    import uc_bridge_pkg::*;

    localparam int PERIOD     = 100;
    localparam int N_RANDOM   = 200;
    localparam int N_TXN      = 60 + 8 + N_RANDOM; // sweeps, stalls, bad opcodes, random mix
    localparam int MAX_STALL  = 8;
    localparam int TXN_CYCLES = 3 * MAX_STALL + 12;

    typedef struct packed {
        tl_a_op_e                op;
        access_size_e            size;
        logic [`UC_ADDR_W-1:0]   addr;
        logic [`UC_MASK_W-1:0]   mask;
        logic [`UC_BEAT_W-1:0]   beat;
        logic [2*`UC_WORD_W-1:0] rdata;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    logic                    req_valid_i;
    logic                    req_wr_i;
    access_size_e            req_size_i;
    logic [`UC_ADDR_W-1:0]   req_addr_i;
    logic [`UC_WORD_W-1:0]   req_wdata_i;
    logic                    resp_done_o;
    logic [2*`UC_WORD_W-1:0] resp_rdata_o;
    logic                    a_valid_o;
    tl_a_op_e                a_opcode_o;
    access_size_e            a_size_o;
    logic [`UC_ADDR_W-1:0]   a_address_o;
    logic [`UC_MASK_W-1:0]   a_mask_o;
    logic [`UC_BEAT_W-1:0]   a_data_o;
    logic                    a_ready_i;
    logic                    d_valid_i;
    tl_d_op_e                d_opcode_i;
    logic [`UC_BEAT_W-1:0]   d_data_i;
    logic                    d_ready_o;

    logic [31:0] rng_state;
    expect_t     cur_exp; // request in flight
    logic        cur_wr;
    string       cur_name;

    dcache_uncached_bridge u_dut (.*);

    bind dcache_uncached_bridge dcache_uncached_bridge_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    initial begin
        #(N_TXN * TXN_CYCLES * PERIOD + 50 * PERIOD);
        stop_with_failure("Timeout: the bridge stopped making progress before the tests ended");
    end

    // first assertion failure in the bound checker ends the run
    initial begin
        wait (u_dut.u_sva.fail_count != 0);
        stop_with_failure("An assertion on the bridge handshakes failed");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // random address, aligned to the access size
    function automatic logic [`UC_ADDR_W-1:0] pick_addr(input access_size_e size);
        return next_rand() & ~((32'd1 << size) - 32'd1);
    endfunction

    // responder memory, every word depends on the whole line address
    function automatic logic [`UC_BEAT_W-1:0] line_data(input logic [`UC_ADDR_W-1:0] addr);
        logic [`UC_BEAT_W-1:0] line;
        logic [`UC_ADDR_W-1:0] base;
        base = {addr[`UC_ADDR_W-1:4], 4'h0};
        for (int i = 0; i < `UC_LANES; i++) begin
            line[i*`UC_WORD_W +: `UC_WORD_W] = (base * 32'h9e37_79b9) ^ (32'h0101_0101 * (i + 1));
        end
        return line;
    endfunction

    function automatic expect_t ref_model(input logic wr, input access_size_e size,
                                          input logic [`UC_ADDR_W-1:0] addr,
                                          input logic [`UC_WORD_W-1:0] wdata);
        expect_t               e;
        logic [`UC_BEAT_W-1:0] line;
        int                    nbytes;
        int                    first;
        int                    lane;
        int                    odd;
        nbytes = 1 << size;
        first  = int'(addr[3:0]) & ~(nbytes - 1); // a dword covers its odd lane too
        lane   = int'(addr[3:2]);
        odd    = lane | 1;
        line   = line_data(addr);
        e.op   = wr ? PutFullData : Get;
        e.size = size;
        e.addr = addr;
        e.mask = '0;
        for (int b = first; b < first + nbytes; b++) begin
            e.mask[b] = 1'b1;
        end
        e.beat = '0;
        e.beat[lane*`UC_WORD_W +: `UC_WORD_W] = wdata;
        e.rdata = {line[odd*`UC_WORD_W +: `UC_WORD_W], line[lane*`UC_WORD_W +: `UC_WORD_W]};
        return e;
    endfunction

    task automatic check_a_op(input string name, input tl_a_op_e exp, input tl_a_op_e act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s opcode expected %0d actual %0d",
                                        name, exp, act));
        end
    endtask

    task automatic check_size(input string name, input access_size_e exp,
                              input access_size_e act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s size expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [`UC_ADDR_W-1:0] exp,
                              input logic [`UC_ADDR_W-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s address expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input logic [`UC_MASK_W-1:0] exp,
                              input logic [`UC_MASK_W-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s mask expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_beat(input string name, input logic [`UC_BEAT_W-1:0] exp,
                              input logic [`UC_BEAT_W-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s beat expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_rdata(input string name, input logic [2*`UC_WORD_W-1:0] exp,
                               input logic [2*`UC_WORD_W-1:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("ERROR %s rdata expected %h actual %h", name, exp, act));
        end
    endtask

    // every cycle the A beat is up it must match, stalled or not
    always @(negedge clk) begin
        if (rst_n && a_valid_o) begin
            check_a_op(cur_name, cur_exp.op, a_opcode_o);
            check_size(cur_name, cur_exp.size, a_size_o);
            check_addr(cur_name, cur_exp.addr, a_address_o);
            check_mask(cur_name, cur_exp.mask, a_mask_o);
            check_beat(cur_name, cur_exp.beat, a_data_o);
        end
        if (rst_n && resp_done_o && !cur_wr) begin
            check_rdata(cur_name, cur_exp.rdata, resp_rdata_o);
        end
    end

    task automatic run_txn(input string name, input logic wr, input access_size_e size,
                           input logic [`UC_ADDR_W-1:0] addr, input logic [`UC_WORD_W-1:0] wdata,
                           input int a_stall, input int d_delay, input int bad_cycles);
        int       waited;
        int       cyc;
        logic     a_done;
        logic     d_done;
        tl_d_op_e good_op;
        tl_d_op_e bad_op;
        good_op = wr ? AccessAck : AccessAckData;
        bad_op  = wr ? AccessAckData : AccessAck;
        @(negedge clk);
        cur_name    = name;
        cur_wr      = wr;
        cur_exp     = ref_model(wr, size, addr, wr ? wdata : '0);
        req_valid_i = 1'b1;
        req_wr_i    = wr;
        req_size_i  = size;
        req_addr_i  = addr;
        req_wdata_i = wr ? wdata : '0; // loads carry no data
        waited = 0;
        a_done = 1'b0;
        while (!a_done) begin
            @(negedge clk);
            a_ready_i = a_valid_o && (waited >= a_stall);
            if (a_valid_o) begin
                waited++;
            end
            a_done = a_ready_i; // beat moves on the coming rising edge
            @(posedge clk);
        end
        cyc    = 0;
        d_done = 1'b0;
        while (!d_done) begin
            @(negedge clk);
            a_ready_i  = 1'b0;
            d_valid_i  = (cyc >= d_delay);
            d_opcode_i = (cyc < d_delay + bad_cycles) ? bad_op : good_op;
            d_data_i   = line_data(addr);
            cyc++;
            #1; // d_ready_o and resp_done_o follow the D inputs
            if (d_valid_i && d_opcode_i == bad_op && d_ready_o) begin
                stop_with_failure($sformatf("%s: a D response with the wrong opcode was taken",
                                            name));
            end
            d_done = d_ready_o;
            if (d_done && wr && resp_done_o !== 1'b1) begin
                stop_with_failure($sformatf("%s: store not done in the AccessAck cycle", name));
            end
            if (d_done && !wr && resp_done_o !== 1'b0) begin
                stop_with_failure($sformatf("%s: load done in the AccessAckData cycle", name));
            end
            @(posedge clk);
        end
        if (!wr) begin
            @(negedge clk);
            d_valid_i = 1'b0;
            if (resp_done_o !== 1'b1) begin
                stop_with_failure($sformatf("%s: load not done after AccessAckData", name));
            end
        end
        @(negedge clk);
        d_valid_i   = 1'b0;
        req_valid_i = 1'b0;
    endtask

    initial begin
        logic [31:0]           r;
        logic [`UC_ADDR_W-1:0] addr;
        logic [`UC_WORD_W-1:0] wdata;
        access_size_e          sz;
        rng_state   = 32'd81;
        rst_n       = 1'b0;
        req_valid_i = 1'b0;
        req_wr_i    = 1'b0;
        req_size_i  = SZ_BYTE;
        req_addr_i  = '0;
        req_wdata_i = '0;
        a_ready_i   = 1'b0;
        d_valid_i   = 1'b0;
        d_opcode_i  = AccessAck;
        d_data_i    = '0;
        cur_exp     = '0;
        cur_wr      = 1'b0;
        cur_name    = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (a_valid_o !== 1'b0 || d_ready_o !== 1'b0 || resp_done_o !== 1'b0) begin
                stop_with_failure("A handshake output was not low after reset without a request");
            end
        end
        // every size at every offset it allows, loads then stores
        for (int wr = 0; wr < 2; wr++) begin
            for (int s = 0; s < 4; s++) begin
                for (int off = 0; off < 16; off += (1 << s)) begin
                    r     = next_rand();
                    wdata = next_rand();
                    run_txn($sformatf("%s_sz%0d_off%0d", wr ? "store" : "load", s, off),
                            wr[0], access_size_e'(s), {r[31:4], 4'(off)}, wdata, 0, 0, 0);
                end
            end
        end
        for (int i = 0; i < 8; i++) begin
            r     = next_rand();
            sz    = access_size_e'(r[1:0]);
            addr  = pick_addr(sz);
            wdata = next_rand();
            if (i < 4) begin
                run_txn($sformatf("a_stall_%0d", i), r[2], sz, addr, wdata,
                        1 + int'(r[6:4]), 0, 0);
            end else begin
                run_txn($sformatf("d_bad_opcode_%0d", i), r[2], sz, addr, wdata,
                        0, int'(r[5:4]), 1 + int'(r[7:6]));
            end
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r     = next_rand();
            sz    = access_size_e'(r[1:0]);
            addr  = pick_addr(sz);
            wdata = next_rand();
            run_txn($sformatf("random_%0d", i), r[2], sz, addr, wdata,
                    r[3] ? int'(r[6:4]) : 0, int'(r[10:8]), 0);
        end
        repeat (4) @(posedge clk);
        if (u_dut.u_sva.fail_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "%0d assertion failures", u_dut.u_sva.fail_count);
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/uc_bridge_pkg.sv
logic/unc_call_if.sv
logic/uncached_req_seq.sv
logic/tl_ul_engine.sv
logic/dcache_uncached_bridge.sv
tb/dcache_uncached_bridge_sva.sv
tb/tb_dcache_uncached_bridge.sv

// File: Bender.yml
package:
  name: dcache_uncached_bridge

sources:
  - include_dirs:
      - logic
    files:
      - logic/uc_bridge_pkg.sv
      - logic/unc_call_if.sv
      - logic/uncached_req_seq.sv
      - logic/tl_ul_engine.sv
      - logic/dcache_uncached_bridge.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/dcache_uncached_bridge_sva.sv
      - tb/tb_dcache_uncached_bridge.sv
